/* ifm_geom_pkg.sv */
package ifm_geom_pkg;

	////////////////////////////////////////////////////////////
	// buffer geometry defaults
	////////////////////////////////////////////////////////////

	// dense lanes carried by one data beat
	// byte n of the wishbone word is lane n, so at most 4
	parameter int BUS_SIZE_DEF = 4;

	// data beats that make up one chunk
	parameter int WR_DAT_CYC_NUM_DEF = 4;

	// width of the bitmap window handed to a prefix sum unit
	// must divide the chunk size (bus size times beat count)
	parameter int PREFIX_SUM_SIZE_DEF = 4;

	// compute units, each with its own pair of read ports
	parameter int COMPUTE_UNIT_NUM_DEF = 2;

endpackage

/* ifm_data_pkg.sv */
package ifm_data_pkg;

	////////////////////////////////////////////////////////////
	// data types shared by loader, banks and read ports
	////////////////////////////////////////////////////////////

	// one activation value
	typedef logic [7:0] ifm_byte_t;

	// wishbone data bus word
	typedef logic [31:0] wb_word_t;

	// wishbone word address, four registers
	typedef logic [1:0] wb_adr_t;

	// loader FSM
	// idle   waiting for a strobe
	// ack    plain access acknowledged, nothing committed
	// commit data beat acknowledged and pushed to the write bank
	typedef enum logic [1:0] {
		LDR_IDLE   = 2'd0,
		LDR_ACK    = 2'd1,
		LDR_COMMIT = 2'd2
	} ldr_state_t;

endpackage

/* ifm_wb_loader.sv */
`timescale 1ns/100ps

module ifm_wb_loader #(
	 parameter int BUS_SIZE       = ifm_geom_pkg::BUS_SIZE_DEF
	,parameter int WR_DAT_CYC_NUM = ifm_geom_pkg::WR_DAT_CYC_NUM_DEF
	,localparam int CNT_W = (WR_DAT_CYC_NUM > 1) ? $clog2(WR_DAT_CYC_NUM) : 1
)(
	 input  logic                                  clk_i
	,input  logic                                  rst_n_i
	,input  logic                                  wb_cyc_i
	,input  logic                                  wb_stb_i
	,input  logic                                  wb_we_i
	,input  ifm_data_pkg::wb_adr_t                 wb_adr_i
	,input  ifm_data_pkg::wb_word_t                wb_dat_i
	,output ifm_data_pkg::wb_word_t                wb_dat_o
	,output logic                                  wb_ack_o
	,output logic [BUS_SIZE-1:0]                   beat_map_o
	,output ifm_data_pkg::ifm_byte_t [BUS_SIZE-1:0] beat_data_o
	,output logic                                  beat_valid_o
	,output logic [CNT_W-1:0]                      beat_count_o
	,output logic                                  wr_sel_o
	,output logic                                  rd_sel_o
);
	import ifm_data_pkg::*;

	// register map, address 0 is bitmap on write and status on read
	localparam wb_adr_t ADR_MAP  = 2'd0;
	localparam wb_adr_t ADR_DATA = 2'd1;

	ldr_state_t               state_q;
	ldr_state_t               state_d;
	logic                     req_w;
	logic                     map_wr_w;
	logic                     dat_wr_w;
	logic                     last_w;
	logic [BUS_SIZE-1:0]      map_q;
	ifm_byte_t [BUS_SIZE-1:0] data_q;
	logic [CNT_W-1:0]         cnt_q;
	logic                     wr_sel_q;
	logic                     rd_sel_q;
	wb_word_t                 status_w;

	////////////////////////////////////////////////////////////
	// wishbone handshake
	////////////////////////////////////////////////////////////

	assign req_w    = wb_cyc_i && wb_stb_i;
	// writes only decoded in idle, the one cycle a request is sampled
	assign map_wr_w = (state_q == LDR_IDLE) && req_w && wb_we_i && (wb_adr_i == ADR_MAP);
	assign dat_wr_w = (state_q == LDR_IDLE) && req_w && wb_we_i && (wb_adr_i == ADR_DATA);

	always_comb begin
		state_d = state_q;
		case (state_q)
			LDR_IDLE: begin
				if (dat_wr_w)
					state_d = LDR_COMMIT;
				else if (req_w)
					state_d = LDR_ACK;
			end
			// ack is one cycle wide, always fall back to idle
			default: state_d = LDR_IDLE;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= LDR_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// staged bitmap, waits for the next data beat
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i)
			map_q <= '0;
		else if (map_wr_w)
			map_q <= wb_dat_i[BUS_SIZE-1:0];
	end

	// lane payload, lane n taken from byte n
	always_ff @(posedge clk_i) begin
		if (dat_wr_w)
			data_q <= wb_dat_i[8*BUS_SIZE-1:0];
	end

	////////////////////////////////////////////////////////////
	// beat counter and ping-pong select
	////////////////////////////////////////////////////////////

	assign last_w = (cnt_q == CNT_W'(WR_DAT_CYC_NUM - 1));

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			cnt_q    <= '0;
			wr_sel_q <= 1'b0;
			rd_sel_q <= 1'b0;
		end else if (state_q == LDR_COMMIT) begin
			if (last_w) begin
				// chunk complete, readers move to the bank just filled
				cnt_q    <= '0;
				wr_sel_q <= ~wr_sel_q;
				rd_sel_q <= wr_sel_q;
			end else begin
				cnt_q <= cnt_q + 1'b1;
			end
		end
	end

	// status word: wr bank, rd bank, beat count
	always_comb begin
		status_w      = '0;
		status_w[0]   = wr_sel_q;
		status_w[1]   = rd_sel_q;
		status_w[5:2] = 4'(cnt_q);
	end

	assign wb_dat_o     = ((state_q == LDR_ACK) && !wb_we_i && (wb_adr_i == ADR_MAP)) ?
	                      status_w : '0;
	assign wb_ack_o     = (state_q != LDR_IDLE);
	assign beat_valid_o = (state_q == LDR_COMMIT);
	assign beat_map_o   = map_q;
	assign beat_data_o  = data_q;
	assign beat_count_o = cnt_q;
	assign wr_sel_o     = wr_sel_q;
	assign rd_sel_o     = rd_sel_q;

endmodule

/* ifm_chunk_bank.sv */
`timescale 1ns/100ps

module ifm_chunk_bank #(
	 parameter int BUS_SIZE       = ifm_geom_pkg::BUS_SIZE_DEF
	,parameter int WR_DAT_CYC_NUM = ifm_geom_pkg::WR_DAT_CYC_NUM_DEF
	,localparam int CHUNK_SIZE = BUS_SIZE * WR_DAT_CYC_NUM
	,localparam int CNT_W      = (WR_DAT_CYC_NUM > 1) ? $clog2(WR_DAT_CYC_NUM) : 1
	,localparam int SLOT_W     = $clog2(CHUNK_SIZE + 1)
)(
	 input  logic                                    clk_i
	,input  logic                                    rst_n_i
	,input  logic [BUS_SIZE-1:0]                     wr_map_i
	,input  ifm_data_pkg::ifm_byte_t [BUS_SIZE-1:0]  wr_data_i
	,input  logic                                    wr_valid_i
	,input  logic [CNT_W-1:0]                        wr_count_i
	,output ifm_data_pkg::ifm_byte_t [CHUNK_SIZE:1]  bank_data_o
	,output logic [CHUNK_SIZE-1:0]                   bank_map_o
);
	import ifm_data_pkg::*;

	// slot 0 does not exist, ordinal slots run 1 to CHUNK_SIZE
	ifm_byte_t [CHUNK_SIZE:1]       slot_q;
	logic [CHUNK_SIZE-1:0]          map_q;
	// nonzero values stored so far in this chunk
	logic [SLOT_W-1:0]              nz_cnt_q;
	logic [SLOT_W-1:0]              base_w;
	logic [SLOT_W-1:0]              nz_next_w;
	logic [BUS_SIZE-1:0][SLOT_W-1:0] lane_slot_w;

	////////////////////////////////////////////////////////////
	// compaction, slot of each set lane
	////////////////////////////////////////////////////////////

	// first beat of a chunk restarts the ordinal count
	assign base_w = (wr_count_i == '0) ? '0 : nz_cnt_q;

	// running sum over lanes in order
	// a lane lands one past the set lanes below it
	always_comb begin
		nz_next_w = base_w;
		for (int l = 0; l < BUS_SIZE; l++) begin
			lane_slot_w[l] = nz_next_w + 1'b1;
			nz_next_w      = nz_next_w + SLOT_W'(wr_map_i[l]);
		end
	end

	////////////////////////////////////////////////////////////
	// storage
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			slot_q   <= '0;
			map_q    <= '0;
			nz_cnt_q <= '0;
		end else if (wr_valid_i) begin
			// wipe stale values from the previous chunk
			// so slots past the nonzero count read zero
			if (wr_count_i == '0)
				slot_q <= '0;
			// set lanes override the wipe
			for (int l = 0; l < BUS_SIZE; l++) begin
				if (wr_map_i[l])
					slot_q[lane_slot_w[l]] <= wr_data_i[l];
			end
			// bitmap segment of this beat
			map_q[wr_count_i*BUS_SIZE +: BUS_SIZE] <= wr_map_i;
			nz_cnt_q <= nz_next_w;
		end
	end

	assign bank_data_o = slot_q;
	assign bank_map_o  = map_q;

endmodule

/* ifm_sparse_window.sv */
`timescale 1ns/100ps

module ifm_sparse_window #(
	 parameter int BUS_SIZE         = ifm_geom_pkg::BUS_SIZE_DEF
	,parameter int WR_DAT_CYC_NUM   = ifm_geom_pkg::WR_DAT_CYC_NUM_DEF
	,parameter int PREFIX_SUM_SIZE  = ifm_geom_pkg::PREFIX_SUM_SIZE_DEF
	,parameter int COMPUTE_UNIT_NUM = ifm_geom_pkg::COMPUTE_UNIT_NUM_DEF
	,localparam int CHUNK_SIZE     = BUS_SIZE * WR_DAT_CYC_NUM
	,localparam int RD_DAT_CYC_NUM = CHUNK_SIZE / PREFIX_SUM_SIZE
	,localparam int SLOT_W         = $clog2(CHUNK_SIZE + 1)
	,localparam int SEG_W          = (RD_DAT_CYC_NUM > 1) ? $clog2(RD_DAT_CYC_NUM) : 1
	,localparam int SHIFT_W        = (PREFIX_SUM_SIZE > 1) ? $clog2(PREFIX_SUM_SIZE) : 1
)(
	 input  ifm_data_pkg::ifm_byte_t [1:0][CHUNK_SIZE:1]     bank_data_i
	,input  logic [1:0][CHUNK_SIZE-1:0]                      bank_map_i
	,input  logic                                            rd_sel_i
	,input  logic [COMPUTE_UNIT_NUM-1:0][SLOT_W-1:0]         rd_addr_i
	,input  logic [COMPUTE_UNIT_NUM-1:0][SEG_W-1:0]          rd_seg_i
	,input  logic [COMPUTE_UNIT_NUM-1:0][SHIFT_W-1:0]        rd_shift_i
	,output ifm_data_pkg::ifm_byte_t [COMPUTE_UNIT_NUM-1:0]  rd_data_o
	,output logic [COMPUTE_UNIT_NUM-1:0][PREFIX_SUM_SIZE-1:0] rd_window_o
);
	import ifm_data_pkg::*;

	// bitmap with zero padding above the chunk end
	localparam int EXT_W   = CHUNK_SIZE + PREFIX_SUM_SIZE;
	localparam int START_W = $clog2(EXT_W);

	////////////////////////////////////////////////////////////
	// per compute unit read ports, all combinational
	////////////////////////////////////////////////////////////

	for (genvar u = 0; u < COMPUTE_UNIT_NUM; u++) begin : g_unit
		ifm_byte_t [CHUNK_SIZE:1] sel_data_w;
		logic [CHUNK_SIZE-1:0]    sel_map_w;
		logic [EXT_W-1:0]         map_ext_w;
		logic [START_W-1:0]       start_w;
		logic [EXT_W-1:0]         shifted_w;
		logic                     addr_ok_w;

		// bank currently handed to the readers
		assign sel_data_w = bank_data_i[rd_sel_i];
		assign sel_map_w  = bank_map_i[rd_sel_i];

		// value port
		// slot 0 means no nonzero yet, reads as zero
		assign addr_ok_w = (rd_addr_i[u] != '0) && (rd_addr_i[u] <= SLOT_W'(CHUNK_SIZE));
		assign rd_data_o[u] = addr_ok_w ? sel_data_w[rd_addr_i[u]] : '0;

		// window port
		// first bit is the position at segment start plus shift
		// every segment, the first one included, follows the same rule
		assign start_w   = START_W'(rd_seg_i[u] * PREFIX_SUM_SIZE + rd_shift_i[u]);
		assign map_ext_w = {{PREFIX_SUM_SIZE{1'b0}}, sel_map_w};

		// shift down, consumed positions drop out at the bottom
		// zeros come in past the last position of the chunk
		assign shifted_w = map_ext_w >> start_w;

		assign rd_window_o[u] = shifted_w[PREFIX_SUM_SIZE-1:0];
	end

endmodule

/* ifm_chunk_stack.sv */
`timescale 1ns/100ps

module ifm_chunk_stack #(
	 parameter int BUS_SIZE         = ifm_geom_pkg::BUS_SIZE_DEF
	,parameter int WR_DAT_CYC_NUM   = ifm_geom_pkg::WR_DAT_CYC_NUM_DEF
	,parameter int PREFIX_SUM_SIZE  = ifm_geom_pkg::PREFIX_SUM_SIZE_DEF
	,parameter int COMPUTE_UNIT_NUM = ifm_geom_pkg::COMPUTE_UNIT_NUM_DEF
	,localparam int CHUNK_SIZE     = BUS_SIZE * WR_DAT_CYC_NUM
	,localparam int RD_DAT_CYC_NUM = CHUNK_SIZE / PREFIX_SUM_SIZE
	,localparam int CNT_W          = (WR_DAT_CYC_NUM > 1) ? $clog2(WR_DAT_CYC_NUM) : 1
	,localparam int SLOT_W         = $clog2(CHUNK_SIZE + 1)
	,localparam int SEG_W          = (RD_DAT_CYC_NUM > 1) ? $clog2(RD_DAT_CYC_NUM) : 1
	,localparam int SHIFT_W        = (PREFIX_SUM_SIZE > 1) ? $clog2(PREFIX_SUM_SIZE) : 1
)(
	 input  logic                                             clk_i
	,input  logic                                             rst_n_i
	,input  logic [BUS_SIZE-1:0]                              beat_map_i
	,input  ifm_data_pkg::ifm_byte_t [BUS_SIZE-1:0]           beat_data_i
	,input  logic                                             beat_valid_i
	,input  logic [CNT_W-1:0]                                 beat_count_i
	,input  logic                                             wr_sel_i
	,input  logic                                             rd_sel_i
	,input  logic [COMPUTE_UNIT_NUM-1:0][SLOT_W-1:0]          rd_addr_i
	,input  logic [COMPUTE_UNIT_NUM-1:0][SEG_W-1:0]           rd_seg_i
	,input  logic [COMPUTE_UNIT_NUM-1:0][SHIFT_W-1:0]         rd_shift_i
	,output ifm_data_pkg::ifm_byte_t [COMPUTE_UNIT_NUM-1:0]   rd_data_o
	,output logic [COMPUTE_UNIT_NUM-1:0][PREFIX_SUM_SIZE-1:0] rd_window_o
);
	import ifm_data_pkg::*;

	// bank indexed views of both stores
	logic [1:0]                       bank_valid_w;
	ifm_byte_t [1:0][CHUNK_SIZE:1]    bank_data_w;
	logic [1:0][CHUNK_SIZE-1:0]       bank_map_w;

	// ping-pong pair, only the write bank sees the beat
	for (genvar b = 0; b < 2; b++) begin : g_bank
		assign bank_valid_w[b] = beat_valid_i && (wr_sel_i == 1'(b));

		ifm_chunk_bank #(
			 .BUS_SIZE       (BUS_SIZE)
			,.WR_DAT_CYC_NUM (WR_DAT_CYC_NUM)
		) ifm_chunk_bank_inst (
			 .clk_i
			,.rst_n_i
			,.wr_map_i    (beat_map_i)
			,.wr_data_i   (beat_data_i)
			,.wr_valid_i  (bank_valid_w[b])
			,.wr_count_i  (beat_count_i)
			,.bank_data_o (bank_data_w[b])
			,.bank_map_o  (bank_map_w[b])
		);
	end

	// drain side, value and window ports of the read bank
	ifm_sparse_window #(
		 .BUS_SIZE         (BUS_SIZE)
		,.WR_DAT_CYC_NUM   (WR_DAT_CYC_NUM)
		,.PREFIX_SUM_SIZE  (PREFIX_SUM_SIZE)
		,.COMPUTE_UNIT_NUM (COMPUTE_UNIT_NUM)
	) ifm_sparse_window_inst (
		 .bank_data_i (bank_data_w)
		,.bank_map_i  (bank_map_w)
		,.rd_sel_i
		,.rd_addr_i
		,.rd_seg_i
		,.rd_shift_i
		,.rd_data_o
		,.rd_window_o
	);

endmodule

/* ifm_buffer_top.sv */
`timescale 1ns/100ps

module ifm_buffer_top #(
	 parameter int BUS_SIZE         = ifm_geom_pkg::BUS_SIZE_DEF
	,parameter int WR_DAT_CYC_NUM   = ifm_geom_pkg::WR_DAT_CYC_NUM_DEF
	,parameter int PREFIX_SUM_SIZE  = ifm_geom_pkg::PREFIX_SUM_SIZE_DEF
	,parameter int COMPUTE_UNIT_NUM = ifm_geom_pkg::COMPUTE_UNIT_NUM_DEF
	,localparam int CHUNK_SIZE     = BUS_SIZE * WR_DAT_CYC_NUM
	,localparam int RD_DAT_CYC_NUM = CHUNK_SIZE / PREFIX_SUM_SIZE
	,localparam int SLOT_W         = $clog2(CHUNK_SIZE + 1)
	,localparam int SEG_W          = (RD_DAT_CYC_NUM > 1) ? $clog2(RD_DAT_CYC_NUM) : 1
	,localparam int SHIFT_W        = (PREFIX_SUM_SIZE > 1) ? $clog2(PREFIX_SUM_SIZE) : 1
)(
	 input  logic                                             clk_i
	,input  logic                                             rst_n_i
	// wishbone classic slave
	,input  logic                                             wb_cyc_i
	,input  logic                                             wb_stb_i
	,input  logic                                             wb_we_i
	,input  ifm_data_pkg::wb_adr_t                            wb_adr_i
	,input  ifm_data_pkg::wb_word_t                           wb_dat_i
	,output ifm_data_pkg::wb_word_t                           wb_dat_o
	,output logic                                             wb_ack_o
	// compute unit read ports
	,input  logic [COMPUTE_UNIT_NUM-1:0][SLOT_W-1:0]          rd_addr_i
	,input  logic [COMPUTE_UNIT_NUM-1:0][SEG_W-1:0]           rd_seg_i
	,input  logic [COMPUTE_UNIT_NUM-1:0][SHIFT_W-1:0]         rd_shift_i
	,output ifm_data_pkg::ifm_byte_t [COMPUTE_UNIT_NUM-1:0]   rd_data_o
	,output logic [COMPUTE_UNIT_NUM-1:0][PREFIX_SUM_SIZE-1:0] rd_window_o
);
	import ifm_data_pkg::*;

	localparam int CNT_W = (WR_DAT_CYC_NUM > 1) ? $clog2(WR_DAT_CYC_NUM) : 1;

	// loader to stack
	logic [BUS_SIZE-1:0]      beat_map_w;
	ifm_byte_t [BUS_SIZE-1:0] beat_data_w;
	logic                     beat_valid_w;
	logic [CNT_W-1:0]         beat_count_w;
	logic                     wr_sel_w;
	logic                     rd_sel_w;

	ifm_wb_loader #(
		 .BUS_SIZE       (BUS_SIZE)
		,.WR_DAT_CYC_NUM (WR_DAT_CYC_NUM)
	) ifm_wb_loader_inst (
		 .clk_i, .rst_n_i, .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i
		,.wb_dat_o, .wb_ack_o
		,.beat_map_o (beat_map_w), .beat_data_o (beat_data_w)
		,.beat_valid_o (beat_valid_w), .beat_count_o (beat_count_w)
		,.wr_sel_o (wr_sel_w), .rd_sel_o (rd_sel_w)
	);

	ifm_chunk_stack #(
		 .BUS_SIZE (BUS_SIZE), .WR_DAT_CYC_NUM (WR_DAT_CYC_NUM)
		,.PREFIX_SUM_SIZE (PREFIX_SUM_SIZE), .COMPUTE_UNIT_NUM (COMPUTE_UNIT_NUM)
	) ifm_chunk_stack_inst (
		 .clk_i, .rst_n_i
		,.beat_map_i (beat_map_w), .beat_data_i (beat_data_w)
		,.beat_valid_i (beat_valid_w), .beat_count_i (beat_count_w)
		,.wr_sel_i (wr_sel_w), .rd_sel_i (rd_sel_w)
		,.rd_addr_i, .rd_seg_i, .rd_shift_i, .rd_data_o, .rd_window_o
	);

endmodule

/* ifm_buffer_asserts.sv */
`timescale 1ns/100ps

module ifm_buffer_asserts #(
	 parameter int WR_DAT_CYC_NUM = ifm_geom_pkg::WR_DAT_CYC_NUM_DEF
	,localparam int CNT_W = (WR_DAT_CYC_NUM > 1) ? $clog2(WR_DAT_CYC_NUM) : 1
)(
	 input logic             clk_i
	,input logic             rst_n_i
	,input logic             wb_cyc_i
	,input logic             wb_stb_i
	,input logic             wb_ack_o
	,input logic             beat_valid_o
	,input logic [CNT_W-1:0] beat_count_o
	,input logic             wr_sel_o
	,input logic             rd_sel_o
);

	logic last_w;
	logic chunk_done_q;

	// last beat of a chunk being committed
	assign last_w = beat_valid_o && (beat_count_o == CNT_W'(WR_DAT_CYC_NUM - 1));

	// set once the first chunk is complete
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i)
			chunk_done_q <= 1'b0;
		else if (last_w)
			chunk_done_q <= 1'b1;
	end

	////////////////////////////////////////////////////////////
	// wishbone handshake
	////////////////////////////////////////////////////////////

	ack_in_request: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		wb_ack_o |-> (wb_cyc_i && wb_stb_i))
		else $error("ack without cyc and stb");

	ack_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		wb_ack_o |=> !wb_ack_o)
		else $error("ack longer than one cycle");

	////////////////////////////////////////////////////////////
	// bank switching
	////////////////////////////////////////////////////////////

	banks_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!last_w |=> ($stable(wr_sel_o) && $stable(rd_sel_o)))
		else $error("bank select moved without a last beat");

	banks_flip: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		last_w |=> (wr_sel_o != $past(wr_sel_o)))
		else $error("write bank kept after a last beat");

	banks_split: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		chunk_done_q |-> (wr_sel_o != rd_sel_o))
		else $error("write and read bank are the same");

endmodule

/* tb_ifm_buffer.sv */
`timescale 1ns/100ps

module tb_ifm_buffer;
	import ifm_geom_pkg::*;
	import ifm_data_pkg::*;

	localparam int BUS_SIZE   = BUS_SIZE_DEF;
	localparam int BEATS      = WR_DAT_CYC_NUM_DEF;
	localparam int PS_SIZE    = PREFIX_SUM_SIZE_DEF;
	localparam int UNITS      = COMPUTE_UNIT_NUM_DEF;
	localparam int CHUNK_SIZE = BUS_SIZE * BEATS;
	localparam int SEGS       = CHUNK_SIZE / PS_SIZE;
	localparam int SLOT_W     = $clog2(CHUNK_SIZE + 1);
	localparam int SEG_W      = (SEGS > 1) ? $clog2(SEGS) : 1;
	localparam int SHIFT_W    = (PS_SIZE > 1) ? $clog2(PS_SIZE) : 1;
	localparam int NROWS      = 8;
	localparam int ACK_WAIT   = 8;

	logic                             clk_i;
	logic                             rst_n_i;
	logic                             wb_cyc;
	logic                             wb_stb;
	logic                             wb_we;
	wb_adr_t                          wb_adr;
	wb_word_t                         wb_dat_w;
	wb_word_t                         wb_dat_r;
	logic                             wb_ack;
	logic [UNITS-1:0][SLOT_W-1:0]     rd_addr;
	logic [UNITS-1:0][SEG_W-1:0]      rd_seg;
	logic [UNITS-1:0][SHIFT_W-1:0]    rd_shift;
	ifm_byte_t [UNITS-1:0]            rd_data;
	logic [UNITS-1:0][PS_SIZE-1:0]    rd_window;

	// chunk table, one row per chunk
	string                            row_name [NROWS];
	logic [BUS_SIZE-1:0]              row_map  [NROWS][BEATS];
	wb_word_t                         row_dat  [NROWS][BEATS];

	// reference model of both banks, slot 0 always zero
	ifm_byte_t                        mdl_val  [2][CHUNK_SIZE+1];
	logic [CHUNK_SIZE-1:0]            mdl_map  [2];
	logic                             mdl_wr;
	logic                             mdl_rd;
	int                               err_cnt;
	int                               pass_cnt;
	int                               fail_cnt;

	initial clk_i = 1'b0;
	always #10 clk_i = ~clk_i;

	ifm_buffer_top ifm_buffer_top_inst (
		 .clk_i       (clk_i)
		,.rst_n_i     (rst_n_i)
		,.wb_cyc_i    (wb_cyc)
		,.wb_stb_i    (wb_stb)
		,.wb_we_i     (wb_we)
		,.wb_adr_i    (wb_adr)
		,.wb_dat_i    (wb_dat_w)
		,.wb_dat_o    (wb_dat_r)
		,.wb_ack_o    (wb_ack)
		,.rd_addr_i   (rd_addr)
		,.rd_seg_i    (rd_seg)
		,.rd_shift_i  (rd_shift)
		,.rd_data_o   (rd_data)
		,.rd_window_o (rd_window)
	);

	// protocol and bank switch checks on the loader
	bind ifm_wb_loader ifm_buffer_asserts #(
		.WR_DAT_CYC_NUM (WR_DAT_CYC_NUM)
	) ifm_buffer_asserts_inst (.*);

	////////////////////////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////////////////////////

	task automatic check_byte(input string name, input ifm_byte_t exp_v, input ifm_byte_t act_v);
		if (act_v !== exp_v) begin
			$display("ERROR %s expected %02h actual %02h", name, exp_v, act_v);
			err_cnt++;
		end
	endtask

	task automatic check_window(input string name, input logic [PS_SIZE-1:0] exp_v,
	                            input logic [PS_SIZE-1:0] act_v);
		if (act_v !== exp_v) begin
			$display("ERROR %s expected %b actual %b", name, exp_v, act_v);
			err_cnt++;
		end
	endtask

	task automatic check_word(input string name, input wb_word_t exp_v, input wb_word_t act_v);
		if (act_v !== exp_v) begin
			$display("ERROR %s expected %08h actual %08h", name, exp_v, act_v);
			err_cnt++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// wishbone master
	////////////////////////////////////////////////////////////

	task automatic wb_access(input logic we, input wb_adr_t adr, input wb_word_t dat,
	                         output wb_word_t rdat);
		int waits;
		@(posedge clk_i);
		#1;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = dat;
		rdat     = '0;
		waits    = 0;
		// ack expected one cycle after the request is sampled
		do begin
			@(posedge clk_i);
			#1;
			waits++;
		end while (!wb_ack && waits < ACK_WAIT);
		if (!wb_ack) begin
			$display("wishbone access to address %0d was never acknowledged", adr);
			err_cnt++;
		end else begin
			rdat = wb_dat_r;
		end
		// release after the edge that samples ack
		@(posedge clk_i);
		#1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
		if (wb_ack) begin
			$display("wishbone ack stayed high for more than one cycle");
			err_cnt++;
		end
	endtask

	task automatic wb_write(input wb_adr_t adr, input wb_word_t dat);
		wb_word_t unused;
		wb_access(1'b1, adr, dat, unused);
	endtask

	task automatic wb_read(input wb_adr_t adr, output wb_word_t rdat);
		wb_access(1'b0, adr, '0, rdat);
	endtask

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////

	// window bit i is bitmap position start + i, zero past the chunk end
	function automatic logic [PS_SIZE-1:0] model_window(input logic [CHUNK_SIZE-1:0] map,
	                                                    input int start);
		logic [PS_SIZE-1:0] w;
		for (int i = 0; i < PS_SIZE; i++)
			w[i] = (start + i < CHUNK_SIZE) ? map[start + i] : 1'b0;
		return w;
	endfunction

	// bit 0 write bank, bit 1 read bank, bits 5:2 beat count
	function automatic wb_word_t status_word(input logic wr, input logic rd, input int cnt);
		wb_word_t w;
		w      = '0;
		w[0]   = wr;
		w[1]   = rd;
		w[5:2] = 4'(cnt);
		return w;
	endfunction

	// pack set lanes in order from slot 1, then swap banks
	task automatic update_model(input int r);
		int nz;
		nz = 0;
		for (int a = 0; a <= CHUNK_SIZE; a++)
			mdl_val[mdl_wr][a] = '0;
		for (int b = 0; b < BEATS; b++) begin
			for (int l = 0; l < BUS_SIZE; l++) begin
				mdl_map[mdl_wr][b*BUS_SIZE + l] = row_map[r][b][l];
				if (row_map[r][b][l]) begin
					nz++;
					mdl_val[mdl_wr][nz] = row_dat[r][b][8*l +: 8];
				end
			end
		end
		mdl_rd = mdl_wr;
		mdl_wr = ~mdl_wr;
	endtask

	////////////////////////////////////////////////////////////
	// read ports
	////////////////////////////////////////////////////////////

	// each unit gets its own address, segment and shift
	task automatic drive_read(input int addr, input int seg, input int shift);
		@(posedge clk_i);
		#1;
		for (int u = 0; u < UNITS; u++) begin
			rd_addr[u]  = SLOT_W'((addr + 5*u) % (CHUNK_SIZE + 1));
			rd_seg[u]   = SEG_W'((seg + u) % SEGS);
			rd_shift[u] = SHIFT_W'((shift + u) % PS_SIZE);
		end
		@(negedge clk_i);
	endtask

	// full sweep, or a short look at the first slots and segment
	task automatic check_bank(input string name, input logic full);
		int last_a;
		int last_s;
		last_a = full ? CHUNK_SIZE : 2;
		last_s = full ? SEGS - 1 : 0;
		for (int a = 0; a <= last_a; a++) begin
			drive_read(a, 0, 0);
			for (int u = 0; u < UNITS; u++)
				check_byte({name, " slot"}, mdl_val[mdl_rd][rd_addr[u]], rd_data[u]);
		end
		for (int s = 0; s <= last_s; s++) begin
			for (int h = 0; h < PS_SIZE; h++) begin
				drive_read(0, s, h);
				for (int u = 0; u < UNITS; u++)
					check_window({name, " window"},
					             model_window(mdl_map[mdl_rd], rd_seg[u]*PS_SIZE + rd_shift[u]),
					             rd_window[u]);
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// chunk table and sequencing
	////////////////////////////////////////////////////////////

	task automatic fill_table();
		for (int r = 0; r < NROWS; r++) begin
			row_name[r] = $sformatf("random_%0d", r);
			for (int b = 0; b < BEATS; b++) begin
				row_map[r][b] = BUS_SIZE'($urandom());
				row_dat[r][b] = $urandom();
			end
		end
		// fixed corner rows up front
		row_name[0] = "all_zero";
		row_name[1] = "all_set";
		row_name[2] = "single";
		for (int b = 0; b < BEATS; b++) begin
			row_map[0][b] = '0;
			row_map[1][b] = '1;
			row_map[2][b] = (b == 2) ? BUS_SIZE'(4) : '0;
		end
	endtask

	task automatic load_row(input int r);
		wb_word_t st;
		for (int b = 0; b < BEATS; b++) begin
			wb_write(2'd0, wb_word_t'(row_map[r][b]));
			wb_write(2'd1, row_dat[r][b]);
			// mid chunk, readers still see the previous chunk
			if (b == 0 && r > 0 && BEATS > 1) begin
				wb_read(2'd0, st);
				check_word({row_name[r], " mid status"}, status_word(mdl_wr, mdl_rd, 1), st);
				check_bank({row_name[r], " mid"}, 1'b0);
			end
		end
		update_model(r);
		wb_read(2'd0, st);
		check_word({row_name[r], " status"}, status_word(mdl_wr, mdl_rd, 0), st);
		check_bank(row_name[r], 1'b1);
	endtask

	task automatic end_test(input string name, input int errs_before);
		if (err_cnt == errs_before) begin
			pass_cnt++;
			$display("test %s done, ok", name);
		end else begin
			fail_cnt++;
			$display("test %s done, %0d mismatches", name, err_cnt - errs_before);
		end
	endtask

	initial begin
		int       errs_before;
		wb_word_t st;
		void'($urandom(32'h6eb2ac7a));
		rst_n_i  = 1'b0;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = '0;
		wb_dat_w = '0;
		rd_addr  = '0;
		rd_seg   = '0;
		rd_shift = '0;
		err_cnt  = 0;
		pass_cnt = 0;
		fail_cnt = 0;
		mdl_wr   = 1'b0;
		mdl_rd   = 1'b0;
		for (int b = 0; b < 2; b++) begin
			mdl_map[b] = '0;
			for (int a = 0; a <= CHUNK_SIZE; a++)
				mdl_val[b][a] = '0;
		end
		fill_table();
		repeat (5) @(posedge clk_i);
		#1;
		rst_n_i = 1'b1;

		// cleared banks and status
		errs_before = err_cnt;
		wb_read(2'd0, st);
		check_word("reset status", '0, st);
		check_bank("reset", 1'b1);
		end_test("reset", errs_before);

		// consecutive rows give the ping-pong sequence
		for (int r = 0; r < NROWS; r++) begin
			errs_before = err_cnt;
			load_row(r);
			end_test(row_name[r], errs_before);
		end

		// unmapped registers leave the buffer alone
		errs_before = err_cnt;
		wb_write(2'd2, $urandom());
		wb_write(2'd3, $urandom());
		wb_read(2'd1, st);
		check_word("read address 1", '0, st);
		wb_read(2'd3, st);
		check_word("read address 3", '0, st);
		wb_read(2'd0, st);
		check_word("unused status", status_word(mdl_wr, mdl_rd, 0), st);
		check_bank("unused", 1'b1);
		end_test("unused_addr", errs_before);

		$display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

/* flist.f */
ifm_geom_pkg.sv
ifm_data_pkg.sv
ifm_wb_loader.sv
ifm_chunk_bank.sv
ifm_sparse_window.sv
ifm_chunk_stack.sv
ifm_buffer_top.sv
ifm_buffer_asserts.sv
tb_ifm_buffer.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_ifm_buffer -f flist.f -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -F '*** PASSED ***' > /dev/null &&
echo "simulation ok" ||
{ echo "simulation failed"; exit 1; }
